// File: Makefile
# Verilator build and run for the stopwatch testbench

LOG := sim.log
SIM := obj_dir/Vstopwatch_tb

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): flist.f design/*.sv verification/*.sv
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module stopwatch_tb -f flist.f

# the log decides, the simulator exit status is not used
run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "PASS: all tests" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: design/button_conditioner.sv
`default_nettype none

module button_conditioner
    import stopwatch_pkg::*;
#(
    parameter int unsigned stable_cycles = debounce_cycles
) (
    input  logic clk,
    input  logic rst,
    input  logic start_n,
    output logic start_pulse
);

    localparam int unsigned cnt_w = $clog2(stable_cycles + 1);

    logic [1:0]       sync_q;
    logic             level_q;
    logic [cnt_w-1:0] stable_cnt;
    logic             accept;

    // released button reads high, so the chain resets to one
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], start_n};
        end
    end

    // synchronized level has disagreed long enough
    assign accept = (sync_q[1] != level_q) && (stable_cnt == cnt_w'(stable_cycles - 1));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            stable_cnt <= '0;
            level_q    <= 1'b1;
        end else if (sync_q[1] == level_q) begin
            // any agreement restarts the count, so short glitches die here
            stable_cnt <= '0;
        end else if (accept) begin
            stable_cnt <= '0;
            level_q    <= sync_q[1];
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    // one cycle request when the debounced level goes low
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            start_pulse <= 1'b0;
        end else begin
            start_pulse <= accept && !sync_q[1];
        end
    end

endmodule

`default_nettype wire

// File: design/digit_scanner.sv
`default_nettype none

module digit_scanner
    import stopwatch_pkg::*;
#(
    parameter int unsigned dwell_cycles = scan_cycles
) (
    input  logic                  clk,
    input  logic                  rst,
    input  time_word_u            time_value,
    output seg_t                  seg,
    output logic [num_digits-1:0] digit_sel
);

    localparam int unsigned dwell_w = $clog2(dwell_cycles + 1);
    localparam int unsigned idx_w   = $clog2(num_digits);

    logic [dwell_w-1:0] dwell_cnt;
    logic               dwell_done;
    logic [idx_w-1:0]   idx;
    logic [idx_w-1:0]   next_idx;
    bcd_t               next_digit;

    assign dwell_done = (dwell_cnt == dwell_w'(dwell_cycles - 1));

    // index of the digit that is shown after this edge
    always_comb begin
        if (!dwell_done) begin
            next_idx = idx;
        end else if (idx == idx_w'(num_digits - 1)) begin
            next_idx = '0;
        end else begin
            next_idx = idx + 1'b1;
        end
    end

    assign next_digit = time_value.digits[next_idx];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dwell_cnt <= '0;
        end else if (dwell_done) begin
            dwell_cnt <= '0;
        end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            idx <= '0;
        end else begin
            idx <= next_idx;
        end
    end

    // select and pattern move together every cycle,
    // so the segments follow time changes within a dwell
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            digit_sel <= ~num_digits'(1);
            seg       <= seg_table[0];
        end else begin
            digit_sel <= ~(num_digits'(1) << next_idx);
            seg       <= seg_table[next_digit];
        end
    end

endmodule

`default_nettype wire

// File: design/hms_counter.sv
`default_nettype none

module hms_counter
    import stopwatch_pkg::*;
#(
    parameter int unsigned tick_cycles = clocks_per_second
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       start_pulse,
    output time_word_u time_value,
    output logic       running
);

    localparam int unsigned presc_w = $clog2(tick_cycles + 1);

    logic [presc_w-1:0] presc;
    logic               tick;

    // carry in bit 4, digit in bits 3:0
    logic [4:0] s_u;
    logic [4:0] s_t;
    logic [4:0] m_u;
    logic [4:0] m_t;
    logic [4:0] h_u;
    logic [4:0] h_t;
    hms_t       next_fields;
    logic       rollover;

    // add carry to one digit, wrapping to zero past its top value
    function automatic logic [4:0] bcd_inc(input bcd_t d, input bcd_t top, input logic cin);
        logic [4:0] result;
        if (!cin) begin
            result = {1'b0, d};
        end else if (d == top) begin
            result = {1'b1, 4'd0};
        end else begin
            result = {1'b0, d + 4'd1};
        end
        return result;
    endfunction

    // free running one second prescaler
    assign tick = (presc == presc_w'(tick_cycles - 1));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            presc <= '0;
        end else if (tick) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // ripple from seconds units up to hours tens
    always_comb begin
        s_u = bcd_inc(time_value.fields.seconds_units, 4'd9, 1'b1);
        s_t = bcd_inc(time_value.fields.seconds_tens,  4'd5, s_u[4]);
        m_u = bcd_inc(time_value.fields.minutes_units, 4'd9, s_t[4]);
        m_t = bcd_inc(time_value.fields.minutes_tens,  4'd5, m_u[4]);
        h_u = bcd_inc(time_value.fields.hours_units,   4'd9, m_t[4]);
        h_t = bcd_inc(time_value.fields.hours_tens,    4'd9, h_u[4]);

        next_fields.seconds_units = s_u[3:0];
        next_fields.seconds_tens  = s_t[3:0];
        next_fields.minutes_units = m_u[3:0];
        next_fields.minutes_tens  = m_t[3:0];
        next_fields.hours_units   = h_u[3:0];
        next_fields.hours_tens    = h_t[3:0];

        // carry out of the top digit means 99:59:59 just passed
        rollover = h_t[4];
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            running    <= 1'b0;
            time_value <= '0;
        end else if (running && tick) begin
            time_value.fields <= next_fields;
            if (rollover) begin
                running <= 1'b0;
            end
        end else if (start_pulse) begin
            // already running means this changes nothing
            running <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/stopwatch_pkg.sv
`default_nettype none

package stopwatch_pkg;

    // default rates for a 50 MHz board clock
    localparam int unsigned clocks_per_second = 32'd50_000_000;
    localparam int unsigned debounce_cycles   = 32'd1_000_000;
    localparam int unsigned scan_cycles       = 32'd50_000;
    localparam int unsigned num_digits        = 32'd6;

    typedef logic [3:0] bcd_t;

    // named view of the time word, hours in the top nibbles
    typedef struct packed {
        bcd_t hours_tens;
        bcd_t hours_units;
        bcd_t minutes_tens;
        bcd_t minutes_units;
        bcd_t seconds_tens;
        bcd_t seconds_units;
    } hms_t;

    // counter works on fields, scanner walks digits (0 = seconds units)
    typedef union packed {
        hms_t                      fields;
        bcd_t [num_digits - 1:0]   digits;
    } time_word_u;

    // segments g..a, a lit segment is driven low
    typedef logic [6:0] seg_t;

    localparam seg_t seg_table [16] = '{
        7'h40,  // 0
        7'h79,  // 1
        7'h24,  // 2
        7'h30,  // 3
        7'h19,  // 4
        7'h12,  // 5
        7'h02,  // 6
        7'h78,  // 7
        7'h00,  // 8
        7'h10,  // 9
        7'h7f, 7'h7f, 7'h7f,
        7'h7f, 7'h7f, 7'h7f
    };

endpackage

`default_nettype wire

// File: design/stopwatch_top.sv
`default_nettype none

module stopwatch_top
    import stopwatch_pkg::*;
#(
    parameter int unsigned tick_cycles   = clocks_per_second,
    parameter int unsigned stable_cycles = debounce_cycles,
    parameter int unsigned dwell_cycles  = scan_cycles
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start_n,
    output time_word_u            time_value,
    output logic                  running,
    output seg_t                  seg,
    output logic [num_digits-1:0] digit_sel
);

    // clean start request from the raw button
    logic start_pulse;

    button_conditioner #(
        .stable_cycles (stable_cycles)
    ) u_button (
        .clk         (clk),
        .rst         (rst),
        .start_n     (start_n),
        .start_pulse (start_pulse)
    );

    hms_counter #(
        .tick_cycles (tick_cycles)
    ) u_counter (
        .clk         (clk),
        .rst         (rst),
        .start_pulse (start_pulse),
        .time_value  (time_value),
        .running     (running)
    );

    // display reads the same time word the counter drives out
    digit_scanner #(
        .dwell_cycles (dwell_cycles)
    ) u_scanner (
        .clk        (clk),
        .rst        (rst),
        .time_value (time_value),
        .seg        (seg),
        .digit_sel  (digit_sel)
    );

endmodule

`default_nettype wire

// File: flist.f
design/stopwatch_pkg.sv
design/button_conditioner.sv
design/hms_counter.sv
design/digit_scanner.sv
design/stopwatch_top.sv
verification/tb_clock_gen.sv
verification/stopwatch_properties.sv
verification/stopwatch_tb.sv

// File: verification/stopwatch_properties.sv
`default_nettype none

module stopwatch_properties
    import stopwatch_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input time_word_u            time_value,
    input logic                  running,
    input logic [num_digits-1:0] digit_sel
);
    timeunit 1ns;
    timeprecision 1ps;

    // number of assertion failures so far
    int unsigned fail_count = 0;

    // exactly one digit enabled, driven low
    digit_sel_onehot: assert property (@(posedge clk) disable iff (!rst)
        $onehot(~digit_sel))
        else begin
            fail_count++;
            $error("digit_sel is not one-hot low: %b", digit_sel);
        end

    // the watch only stops at the rollover to zero
    running_falls_at_zero: assert property (@(posedge clk) disable iff (!rst)
        $fell(running) |-> (time_value == '0))
        else begin
            fail_count++;
            $error("running fell with time_value %h", time_value);
        end

    time_moves_while_running: assert property (@(posedge clk) disable iff (!rst)
        $changed(time_value) |-> ($past(running) || (time_value == '0)))
        else begin
            fail_count++;
            $error("time_value changed to %h while stopped", time_value);
        end

endmodule

bind stopwatch_top stopwatch_properties u_properties (
    .clk        (clk),
    .rst        (rst),
    .time_value (time_value),
    .running    (running),
    .digit_sel  (digit_sel)
);

`default_nettype wire

// File: verification/stopwatch_tb.sv
`default_nettype none

module stopwatch_tb
    import stopwatch_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned tick   = 4;
    localparam int unsigned stable = 3;
    localparam int unsigned dwell  = 2;
    // a full run to 99:59:59 plus margin
    localparam longint unsigned timeout_ns = 64'd400_000 * tick * 8 + 64'd100_000;

    logic                  clk;
    logic                  rst;
    logic                  start_n;
    time_word_u            time_value;
    logic                  running;
    seg_t                  seg;
    logic [num_digits-1:0] digit_sel;

    logic [31:0] lfsr_state = 32'he23b_4189;
    time_word_u  prev_time;

    tb_clock_gen u_clock (
        .clk (clk),
        .rst (rst)
    );

    stopwatch_top #(
        .tick_cycles   (tick),
        .stable_cycles (stable),
        .dwell_cycles  (dwell)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .start_n    (start_n),
        .time_value (time_value),
        .running    (running),
        .seg        (seg),
        .digit_sel  (digit_sel)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_bits(input int unsigned n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // count in plain seconds, wrap after 99:59:59
    function automatic time_word_u next_time(input time_word_u t);
        int unsigned secs;
        int unsigned hours;
        int unsigned mins;
        time_word_u  r;
        hours = 10 * int'(t.fields.hours_tens) + int'(t.fields.hours_units);
        mins  = 10 * int'(t.fields.minutes_tens) + int'(t.fields.minutes_units);
        secs  = hours * 3600 + mins * 60;
        secs  = secs + 10 * int'(t.fields.seconds_tens) + int'(t.fields.seconds_units);
        secs  = (secs + 1) % 360_000;
        hours = secs / 3600;
        mins  = (secs / 60) % 60;
        r.fields.hours_tens    = bcd_t'(hours / 10);
        r.fields.hours_units   = bcd_t'(hours % 10);
        r.fields.minutes_tens  = bcd_t'(mins / 10);
        r.fields.minutes_units = bcd_t'(mins % 10);
        r.fields.seconds_tens  = bcd_t'((secs % 60) / 10);
        r.fields.seconds_units = bcd_t'(secs % 10);
        return r;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("Error at %0d ns: %s is %0h, expected %0h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic press_for(input int unsigned cycles);
        @(negedge clk);
        start_n = 1'b0;
        repeat (cycles) @(negedge clk);
        start_n = 1'b1;
    endtask

    // wait for the next second and compare it with the predicted one
    task automatic follow_tick(input bit check_interval, input logic expect_running);
        int unsigned cycles;
        time_word_u  expected;
        expected = next_time(prev_time);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 4 * tick) begin
                fail_run("time_value did not advance within four tick periods");
            end
        end while (time_value === prev_time);
        check_value("time_value", time_value, expected);
        if (check_interval) begin
            check_value("cycles between changes", cycles, tick);
        end
        check_value("running", running, expect_running);
        prev_time = time_value;
    endtask

    task automatic track_changes(input int unsigned n, input bit first_free);
        for (int unsigned k = 0; k < n; k++) begin
            follow_tick(!(first_free && k == 0), 1'b1);
        end
    endtask

    task automatic scan_display(input int unsigned n);
        time_word_u            last_time;
        logic [num_digits-1:0] seen;
        int unsigned           idx;
        int unsigned           prev_idx;
        int unsigned           zeros;
        int unsigned           held;
        int unsigned           changes;
        seen = '0;
        idx = 0;
        held = 0;
        changes = 0;
        for (int unsigned k = 0; k <= n; k++) begin
            @(negedge clk);
            zeros = 0;
            for (int i = 0; i < num_digits; i++) begin
                if (!digit_sel[i]) begin
                    zeros++;
                    idx = i;
                end
            end
            check_value("digit_sel low bits", zeros, 1);
            if (k > 0) begin
                // seg was loaded from the time word of the previous cycle
                check_value("seg", seg, seg_table[last_time.digits[idx]]);
                if (idx != prev_idx) begin
                    check_value("digit index", idx, (prev_idx + 1) % num_digits);
                    // the first run seen may have started before sampling
                    if (changes > 0) begin
                        check_value("dwell cycles", held, dwell);
                    end
                    changes++;
                    held = 0;
                end
            end
            held++;
            seen[idx] = 1'b1;
            prev_idx = idx;
            last_time = time_value;
        end
        check_value("digits shown", seen, {num_digits{1'b1}});
    endtask

    task automatic reset_test();
        wait (rst === 1'b1);
        check_value("running", running, 1'b0);
        check_value("time_value", time_value, '0);
        check_value("digit_sel", digit_sel, {{(num_digits - 1){1'b1}}, 1'b0});
        check_value("seg", seg, seg_table[0]);
    endtask

    task automatic debounce_test();
        logic [31:0] len;
        int unsigned waited;
        for (int g = 0; g < 4; g++) begin
            random_bits(1, len);
            press_for(len + 1);
            repeat (20) begin
                @(negedge clk);
                check_value("running", running, 1'b0);
                check_value("time_value", time_value, '0);
            end
        end
        @(negedge clk);
        start_n = 1'b0;
        waited = 0;
        while (running !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > stable + 10) begin
                fail_run("running did not rise after a held press");
            end
        end
        start_n = 1'b1;
        prev_time = time_value;
    endtask

    task automatic counting_test();
        track_changes(125, 1'b1);
    endtask

    task automatic ignored_press_test();
        logic [31:0] gap;
        fork
            begin
                random_bits(2, gap);
                repeat (gap + 1) @(negedge clk);
                press_for(stable + 6);
            end
            track_changes(12, 1'b0);
        join
    endtask

    task automatic display_test();
        fork
            scan_display(dwell * num_digits * 3);
            track_changes(10, 1'b0);
        join
    endtask

    task automatic rollover_test();
        while (prev_time !== 24'h99_5959) begin
            follow_tick(1'b1, 1'b1);
        end
        follow_tick(1'b1, 1'b0);
        check_value("time_value", time_value, '0);
        repeat (3 * tick) begin
            @(negedge clk);
            check_value("running", running, 1'b0);
            check_value("time_value", time_value, '0);
        end
    endtask

    initial begin
        #(timeout_ns);
        fail_run("watchdog expired before the tests finished");
    end

    // the bound checker counts its own failures
    initial begin
        wait (uut.u_properties.fail_count != 0);
        fail_run("an assertion in stopwatch_properties failed");
    end

    initial begin
        start_n = 1'b1;
        prev_time = '0;
        reset_test();
        debounce_test();
        counting_test();
        ignored_press_test();
        display_test();
        rollover_test();
        if (uut.u_properties.fail_count != 0) begin
            fail_run("assertions in stopwatch_properties failed");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam realtime half_period = 4.0;
    localparam int unsigned reset_cycles = 2;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

endmodule

`default_nettype wire
